/* rtl/alu_pkg.sv */
`default_nettype none

package alu_pkg;

    localparam int xlen = 32;  // data width.

    // result select, picks which unit drives the result.
    typedef enum logic [1:0] {
        alu_add_sub = 2'b00,
        alu_slt     = 2'b01,
        alu_rshift  = 2'b10,
        alu_lshift  = 2'b11
    } alu_op_e;

    // operation formed on the first adder input.
    typedef enum logic [1:0] {
        logic_xor = 2'b00,
        logic_or  = 2'b01,
        logic_and = 2'b10,
        logic_add = 2'b11
    } logic_op_e;

    localparam logic [6:0] opcode_op     = 7'b0110011;  // register-register ops.
    localparam logic [6:0] opcode_op_imm = 7'b0010011;  // register-immediate ops.

    // funct3 values shared by OP and OP-IMM.
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    typedef struct packed {
        logic [6:0] funct7;  // bit 5 selects SUB and SRA.
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm12;  // sign-extended to form the immediate.
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    // one instruction word, read as R-type or I-type.
    typedef union packed {
        r_type_t r;
        i_type_t i;
    } instr_u;

    // id width for a given number of in-flight slots, at least one bit.
    function automatic int id_bits(input int depth);
        return (depth > 1) ? $clog2(depth) : 1;
    endfunction

    // mirror a data word, lets one right shifter do left shifts too.
    function automatic logic [xlen-1:0] bit_reverse(input logic [xlen-1:0] x);
        logic [xlen-1:0] r;
        for (int b = 0; b < xlen; b++) begin
            r[b] = x[xlen-1-b];
        end
        return r;
    endfunction

endpackage

`default_nettype wire

/* rtl/alu_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_decode (
    input  wire                          issue_valid,
    input  wire  [31:0]                  issue_instr,
    input  wire  [alu_pkg::xlen-1:0]     rs1_data,
    input  wire  [alu_pkg::xlen-1:0]     rs2_data,
    output logic [alu_pkg::xlen-1:0]     in1,
    output logic [alu_pkg::xlen-1:0]     in2,
    output logic [alu_pkg::xlen-1:0]     shifter_in,
    output logic                         subtract,
    output logic                         is_unsigned,
    output logic                         arith,
    output logic                         lshift,
    output alu_pkg::logic_op_e           logic_op,
    output alu_pkg::alu_op_e             op,
    output logic [4:0]                   rd_addr,
    output logic                         illegal
);

    alu_pkg::instr_u         instr;    // same word, two views.
    logic                    is_op;
    logic                    is_op_imm;
    logic [2:0]              funct3;
    logic                    alt;      // funct7[5], also imm12[10] for shifts.
    logic [alu_pkg::xlen-1:0] imm_ext;

    assign instr     = issue_instr;
    assign funct3    = instr.r.funct3;
    assign alt       = instr.r.funct7[5];
    assign is_op     = (instr.r.opcode == alu_pkg::opcode_op);
    assign is_op_imm = (instr.i.opcode == alu_pkg::opcode_op_imm);

    // sign-extend the 12-bit immediate.
    assign imm_ext = {{(alu_pkg::xlen-12){instr.i.imm12[11]}}, instr.i.imm12};

    assign in1 = rs1_data;
    assign in2 = is_op_imm ? imm_ext : rs2_data;  // shamt sits in the low 5 bits either way.

    // left shifts go through the right shifter on a mirrored operand.
    assign shifter_in = lshift ? alu_pkg::bit_reverse(rs1_data) : rs1_data;

    assign rd_addr = instr.r.rd;

    // anything outside OP and OP-IMM is flagged.
    assign illegal = issue_valid & ~(is_op | is_op_imm);

    always_comb begin
        op          = alu_pkg::alu_add_sub;  // defaults give a plain add.
        logic_op    = alu_pkg::logic_add;
        subtract    = 1'b0;
        is_unsigned = 1'b0;
        arith       = 1'b0;
        lshift      = 1'b0;
        case (funct3)
            alu_pkg::f3_add_sub: subtract = is_op & alt;  // SUB exists only in OP.
            alu_pkg::f3_sll: begin
                op     = alu_pkg::alu_lshift;
                lshift = 1'b1;
            end
            alu_pkg::f3_slt: begin
                op       = alu_pkg::alu_slt;
                subtract = 1'b1;                          // compare by subtraction.
            end
            alu_pkg::f3_sltu: begin
                op          = alu_pkg::alu_slt;
                subtract    = 1'b1;
                is_unsigned = 1'b1;                       // zero-extend operands.
            end
            alu_pkg::f3_xor: logic_op = alu_pkg::logic_xor;
            alu_pkg::f3_srl_sra: begin
                op    = alu_pkg::alu_rshift;
                arith = alt;                              // SRA/SRAI fill with sign.
            end
            alu_pkg::f3_or:  logic_op = alu_pkg::logic_or;
            alu_pkg::f3_and: logic_op = alu_pkg::logic_and;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/barrel_shifter.sv */
`timescale 1ns/1ps
`default_nettype none

module barrel_shifter (
    input  wire  [alu_pkg::xlen-1:0] shifter_input,
    input  wire  [4:0]               shift_amount,
    input  wire                      arith,
    input  wire                      lshift,
    output logic [alu_pkg::xlen-1:0] shifted_resultr,
    output logic [alu_pkg::xlen-1:0] shifted_resultl
);

    logic                    fill;     // bit shifted in from the top.
    logic [alu_pkg::xlen:0]  extended; // one extra bit carries the fill.
    logic [alu_pkg::xlen:0]  shifted;

    // sign fill only for arithmetic right shifts.
    // a mirrored left operand must always shift in zeros.
    assign fill = arith & ~lshift & shifter_input[alu_pkg::xlen-1];

    assign extended = {fill, shifter_input};

    // one 33-bit arithmetic shift covers logical and arithmetic cases.
    assign shifted = $signed(extended) >>> shift_amount;

    assign shifted_resultr = shifted[alu_pkg::xlen-1:0];

    // mirror back to get the left shift.
    assign shifted_resultl = alu_pkg::bit_reverse(shifted[alu_pkg::xlen-1:0]);

endmodule

`default_nettype wire

/* rtl/alu_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_unit #(
    parameter int INFLIGHT_DEPTH = 4
) (
    input  wire                                          clk,
    input  wire                                          rst,
    input  wire  [alu_pkg::xlen-1:0]                     in1,
    input  wire  [alu_pkg::xlen-1:0]                     in2,
    input  wire  [alu_pkg::xlen-1:0]                     shifter_in,
    input  wire                                          subtract,
    input  wire                                          is_unsigned,
    input  wire                                          arith,
    input  wire                                          lshift,
    input  wire  alu_pkg::logic_op_e                     logic_op,
    input  wire  alu_pkg::alu_op_e                       op,
    input  wire                                          illegal,
    input  wire                                          issue_valid,
    input  wire  [alu_pkg::id_bits(INFLIGHT_DEPTH)-1:0]  issue_id,
    input  wire  [alu_pkg::id_bits(INFLIGHT_DEPTH)-1:0]  rd_id,
    output logic [alu_pkg::xlen-1:0]                     rd_data
);

    localparam int xlen = alu_pkg::xlen;

    logic [xlen:0]   in1_ext;         // extended by sign or zero.
    logic [xlen:0]   in2_ext;
    logic [xlen:0]   adder_in1;
    logic [xlen:0]   adder_in2;
    logic [xlen+1:0] chain_sum;       // bit 0 only carries subtract in.
    logic [xlen:0]   add_sub_result;
    logic [xlen-1:0] rshift_result;
    logic [xlen-1:0] lshift_result;
    logic [xlen-1:0] result;
    logic [xlen-1:0] rd_bank [INFLIGHT_DEPTH];

    // top bit decides signed vs unsigned compare.
    assign in1_ext = {~is_unsigned & in1[xlen-1], in1};
    assign in2_ext = {~is_unsigned & in2[xlen-1], in2};

    // logic ops reuse the carry chain with a zero second input.
    always_comb begin
        case (logic_op)
            alu_pkg::logic_xor: adder_in1 = in1_ext ^ in2_ext;
            alu_pkg::logic_or:  adder_in1 = in1_ext | in2_ext;
            alu_pkg::logic_and: adder_in1 = in1_ext & in2_ext;
            default:            adder_in1 = in1_ext;
        endcase
        if (logic_op == alu_pkg::logic_add) begin
            adder_in2 = in2_ext ^ {(xlen+1){subtract}};  // one's complement for SUB.
        end else begin
            adder_in2 = '0;
        end
    end

    // the extra low bit feeds subtract in as the carry.
    assign chain_sum      = {adder_in1, subtract} + {adder_in2, subtract};
    assign add_sub_result = chain_sum[xlen+1:1];

    barrel_shifter u_shifter (
        .shifter_input   (shifter_in),
        .shift_amount    (in2[4:0]),
        .arith           (arith),
        .lshift          (lshift),
        .shifted_resultr (rshift_result),
        .shifted_resultl (lshift_result)
    );

    // result select.
    always_comb begin
        case (op)
            alu_pkg::alu_add_sub: result = add_sub_result[xlen-1:0];
            alu_pkg::alu_slt:     result = {{(xlen-1){1'b0}}, add_sub_result[xlen]};
            alu_pkg::alu_rshift:  result = rshift_result;
            default:              result = lshift_result;
        endcase
    end

    // bank written in the issue cycle, one slot per id.
    always_ff @(posedge clk) begin
        if (issue_valid && !rst) begin
            rd_bank[issue_id] <= illegal ? '0 : result;  // illegal ops write zero.
        end
    end

    assign rd_data = rd_bank[rd_id];  // read for the queue head.

endmodule

`default_nettype wire

/* rtl/writeback_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module writeback_queue #(
    parameter int INFLIGHT_DEPTH = 4,
    parameter int WB_CREDITS     = 2
) (
    input  wire                                          clk,
    input  wire                                          rst,
    input  wire                                          issue_valid,
    input  wire  [alu_pkg::id_bits(INFLIGHT_DEPTH)-1:0]  issue_id,
    input  wire  [4:0]                                   rd_addr,
    input  wire                                          illegal,
    input  wire                                          wb_credit,
    output logic [alu_pkg::id_bits(INFLIGHT_DEPTH)-1:0]  head_id,
    input  wire  [alu_pkg::xlen-1:0]                     bank_data,
    output logic                                         wb_valid,
    output logic [alu_pkg::id_bits(INFLIGHT_DEPTH)-1:0]  wb_id,
    output logic [4:0]                                   wb_rd_addr,
    output logic [alu_pkg::xlen-1:0]                     wb_data,
    output logic                                         wb_illegal,
    output logic                                         issue_credit
);

    localparam int id_w     = alu_pkg::id_bits(INFLIGHT_DEPTH);
    localparam int cnt_w    = $clog2(INFLIGHT_DEPTH + 1);
    // room for the initial grant plus returns arriving early.
    localparam int credit_w = $clog2(WB_CREDITS + INFLIGHT_DEPTH + 1) + 1;
    localparam logic [id_w-1:0] last_slot = id_w'(INFLIGHT_DEPTH - 1);

    logic [id_w-1:0]     id_q  [INFLIGHT_DEPTH];  // entries in issue order.
    logic [4:0]          rd_q  [INFLIGHT_DEPTH];
    logic                ill_q [INFLIGHT_DEPTH];
    logic [id_w-1:0]     wr_ptr;
    logic [id_w-1:0]     rd_ptr;
    logic [cnt_w-1:0]    count;       // occupied slots.
    logic [credit_w-1:0] credit_cnt;  // downstream credits held.
    logic                send;

    // head leaves when there is one and downstream can take it.
    assign send = (count != '0) && (credit_cnt != '0);

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            id_q[wr_ptr]  <= issue_id;
            rd_q[wr_ptr]  <= rd_addr;
            ill_q[wr_ptr] <= illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credit_cnt <= credit_w'(WB_CREDITS);
        end else begin
            if (issue_valid) begin
                wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;  // wrap at depth.
            end
            if (send) begin
                rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
            end
            count      <= count + cnt_w'(issue_valid) - cnt_w'(send);
            credit_cnt <= credit_cnt + credit_w'(wb_credit) - credit_w'(send);
        end
    end

    assign head_id = id_q[rd_ptr];  // bank read address.

    assign wb_valid     = send;
    assign wb_id        = id_q[rd_ptr];
    assign wb_rd_addr   = rd_q[rd_ptr];
    assign wb_data      = bank_data;
    assign wb_illegal   = ill_q[rd_ptr];
    assign issue_credit = send;  // slot frees as the entry leaves.

endmodule

`default_nettype wire

/* rtl/alu_exec_top.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_exec_top #(
    parameter int INFLIGHT_DEPTH = 4,
    parameter int WB_CREDITS     = 2
) (
    input  wire                                          clk,
    input  wire                                          rst,
    input  wire                                          issue_valid,
    input  wire  [alu_pkg::id_bits(INFLIGHT_DEPTH)-1:0]  issue_id,
    input  wire  [31:0]                                  issue_instr,
    input  wire  [alu_pkg::xlen-1:0]                     rs1_data,
    input  wire  [alu_pkg::xlen-1:0]                     rs2_data,
    output logic                                         issue_credit,
    output logic                                         wb_valid,
    output logic [alu_pkg::id_bits(INFLIGHT_DEPTH)-1:0]  wb_id,
    output logic [4:0]                                   wb_rd_addr,
    output logic [alu_pkg::xlen-1:0]                     wb_data,
    output logic                                         wb_illegal,
    input  wire                                          wb_credit
);

    localparam int id_w = alu_pkg::id_bits(INFLIGHT_DEPTH);

    logic [alu_pkg::xlen-1:0] in1;          // decoded operands.
    logic [alu_pkg::xlen-1:0] in2;
    logic [alu_pkg::xlen-1:0] shifter_in;
    logic                     subtract;
    logic                     is_unsigned;
    logic                     arith;
    logic                     lshift;
    alu_pkg::logic_op_e       logic_op;
    alu_pkg::alu_op_e         op;
    logic [4:0]               rd_addr;
    logic                     illegal;
    logic [id_w-1:0]          head_id;      // queue head into the bank.
    logic [alu_pkg::xlen-1:0] bank_data;

    alu_decode u_decode (
        .issue_valid (issue_valid),
        .issue_instr (issue_instr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .in1         (in1),
        .in2         (in2),
        .shifter_in  (shifter_in),
        .subtract    (subtract),
        .is_unsigned (is_unsigned),
        .arith       (arith),
        .lshift      (lshift),
        .logic_op    (logic_op),
        .op          (op),
        .rd_addr     (rd_addr),
        .illegal     (illegal)
    );

    alu_unit #(
        .INFLIGHT_DEPTH (INFLIGHT_DEPTH)
    ) u_alu (
        .clk         (clk),
        .rst         (rst),
        .in1         (in1),
        .in2         (in2),
        .shifter_in  (shifter_in),
        .subtract    (subtract),
        .is_unsigned (is_unsigned),
        .arith       (arith),
        .lshift      (lshift),
        .logic_op    (logic_op),
        .op          (op),
        .illegal     (illegal),
        .issue_valid (issue_valid),
        .issue_id    (issue_id),
        .rd_id       (head_id),
        .rd_data     (bank_data)
    );

    writeback_queue #(
        .INFLIGHT_DEPTH (INFLIGHT_DEPTH),
        .WB_CREDITS     (WB_CREDITS)
    ) u_queue (
        .clk          (clk),
        .rst          (rst),
        .issue_valid  (issue_valid),
        .issue_id     (issue_id),
        .rd_addr      (rd_addr),
        .illegal      (illegal),
        .wb_credit    (wb_credit),
        .head_id      (head_id),
        .bank_data    (bank_data),
        .wb_valid     (wb_valid),
        .wb_id        (wb_id),
        .wb_rd_addr   (wb_rd_addr),
        .wb_data      (wb_data),
        .wb_illegal   (wb_illegal),
        .issue_credit (issue_credit)
    );

endmodule

`default_nettype wire

/* sim/alu_exec_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_exec_chk #(
    parameter int INFLIGHT_DEPTH = 4,
    parameter int WB_CREDITS     = 2,
    parameter int CNT_W          = 3
) (
    input wire             clk,
    input wire             rst,
    input wire             issue_valid,
    input wire             wb_credit,
    input wire             wb_valid,
    input wire             issue_credit,
    input wire [CNT_W-1:0] count
);

    int violations = 0;  // failed assertions so far.
    int granted;         // downstream credits, counted from the port pulses alone.

    always_ff @(posedge clk) begin
        if (rst) begin
            granted <= WB_CREDITS;
        end else begin
            granted <= granted + (wb_credit ? 1 : 0) - (wb_valid ? 1 : 0);
        end
    end

    // a push into a full queue is only legal with a pop in the same cycle.
    queue_no_overflow: assert property (@(posedge clk) disable iff (rst)
        (count <= INFLIGHT_DEPTH) && !(issue_valid && count == INFLIGHT_DEPTH && !wb_valid))
    else begin
        violations++;
        $error("writeback queue overflow");
    end

    send_needs_credit: assert property (@(posedge clk) disable iff (rst)
        wb_valid |-> granted > 0)
    else begin
        violations++;
        $error("writeback sent without a downstream credit");
    end

    // one issue credit per result that leaves.
    credit_tracks_send: assert property (@(posedge clk) disable iff (rst)
        issue_credit == wb_valid)
    else begin
        violations++;
        $error("issue_credit differs from wb_valid");
    end

endmodule

bind writeback_queue alu_exec_chk #(
    .INFLIGHT_DEPTH (INFLIGHT_DEPTH),
    .WB_CREDITS     (WB_CREDITS),
    .CNT_W          (cnt_w)
) u_chk (
    .clk          (clk),
    .rst          (rst),
    .issue_valid  (issue_valid),
    .wb_credit    (wb_credit),
    .wb_valid     (wb_valid),
    .issue_credit (issue_credit),
    .count        (count)
);

`default_nettype wire

/* sim/alu_exec_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_exec_tb;

    localparam int INFLIGHT_DEPTH = 4;
    localparam int WB_CREDITS     = 2;
    localparam int id_w           = $clog2(INFLIGHT_DEPTH);
    localparam int n_random       = 200;
    localparam int run_cycles     = 500 + n_random * 8;  // directed tests plus random ops.
    localparam logic [6:0] op_reg = 7'b0110011;
    localparam logic [6:0] op_imm = 7'b0010011;

    typedef struct packed {
        logic [id_w-1:0] id;
        logic [4:0]      rd;
        logic [31:0]     data;
        logic            ill;
    } wb_rec_t;

    logic            clk = 1'b0;
    logic            rst;
    logic            issue_valid;
    logic [id_w-1:0] issue_id;
    logic [31:0]     issue_instr;
    logic [31:0]     rs1_data;
    logic [31:0]     rs2_data;
    logic            wb_credit;
    logic            issue_credit;
    logic            wb_valid;
    logic [id_w-1:0] wb_id;
    logic [4:0]      wb_rd_addr;
    logic [31:0]     wb_data;
    logic            wb_illegal;

    wb_rec_t exp_q[$];                // expected writebacks, issue order.
    int      credits;                 // issue credits held here.
    int      owed;                    // downstream credits still to return.
    logic    busy [INFLIGHT_DEPTH];   // ids in flight.
    logic    release_en;
    logic    random_release;
    logic    pick_random;
    logic    give_credit;

    always #5 clk = ~clk;

    alu_exec_top #(
        .INFLIGHT_DEPTH (INFLIGHT_DEPTH),
        .WB_CREDITS     (WB_CREDITS)
    ) u_alu_exec_top (
        .clk          (clk),
        .rst          (rst),
        .issue_valid  (issue_valid),
        .issue_id     (issue_id),
        .issue_instr  (issue_instr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .issue_credit (issue_credit),
        .wb_valid     (wb_valid),
        .wb_id        (wb_id),
        .wb_rd_addr   (wb_rd_addr),
        .wb_data      (wb_data),
        .wb_illegal   (wb_illegal),
        .wb_credit    (wb_credit)
    );

    task automatic stop_run();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic bad_value(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        stop_run();
    endtask

    task automatic timed_out(input string what);
        $display("timeout while %s", what);
        stop_run();
    endtask

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, 5'd2, 5'd1, f3, rd, op_reg};
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {imm, 5'd1, f3, rd, op_imm};
    endfunction

    // RV32I semantics, returns {illegal, result}.
    function automatic logic [32:0] ref_result(input logic [31:0] instr, input logic [31:0] a,
                                               input logic [31:0] b_reg);
        logic [31:0] b;
        logic [4:0]  sh;
        logic [31:0] r;
        if (instr[6:0] == op_reg) b = b_reg;
        else if (instr[6:0] == op_imm) b = {{20{instr[31]}}, instr[31:20]};
        else return {1'b1, 32'h0};
        sh = b[4:0];
        case (instr[14:12])
            3'd0: r = (instr[6:0] == op_reg && instr[30]) ? a - b : a + b;
            3'd1: r = a << sh;
            3'd2: r = {31'd0, $signed(a) < $signed(b)};
            3'd3: r = {31'd0, a < b};
            3'd4: r = a ^ b;
            3'd5: r = instr[30] ? 32'($signed(a) >>> sh) : a >> sh;  // SRA vs SRL.
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return {1'b0, r};
    endfunction

    // starts and ends 1 ns after a rising edge, so issues can run back to back.
    task automatic issue_one(input logic [31:0] instr, input logic [31:0] a,
                             input logic [31:0] b);
        logic [32:0] r;
        int          free_ids[$];
        int          id;
        int          waited;
        waited = 0;
        while (credits == 0) begin
            issue_valid = 1'b0;
            @(posedge clk);
            #1;
            waited++;
            if (waited > 100) timed_out("waiting for an issue credit");
        end
        for (int k = 0; k < INFLIGHT_DEPTH; k++) begin
            if (!busy[k]) free_ids.push_back(k);
        end
        assert (free_ids.size() > 0) else begin
            $display("no free id although an issue credit is held");
            stop_run();
        end
        id = pick_random ? free_ids[$urandom_range(free_ids.size() - 1)] : free_ids[0];
        r = ref_result(instr, a, b);
        issue_valid = 1'b1;
        issue_id    = id_w'(id);
        issue_instr = instr;
        rs1_data    = a;
        rs2_data    = b;
        exp_q.push_back(wb_rec_t'{id_w'(id), instr[11:7], r[31:0], r[32]});
        busy[id] = 1'b1;
        credits--;
        @(posedge clk);
        #1;
        issue_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 || owed != 0 || credits != INFLIGHT_DEPTH) begin
            @(posedge clk);
            #1;
            n++;
            if (n > 100) timed_out("draining the writeback queue");
        end
    endtask

    // writeback monitor and downstream model, both on the falling edge.
    always @(negedge clk) begin
        wb_rec_t e;
        if (!rst) begin
            assert (u_alu_exec_top.u_queue.u_chk.violations == 0) else begin
                $display("a bound queue assertion failed");
                stop_run();
            end
            if (wb_valid) begin
                assert (exp_q.size() > 0) else begin
                    $display("writeback seen with nothing in flight");
                    stop_run();
                end
                e = exp_q.pop_front();
                assert (wb_id == e.id && wb_rd_addr == e.rd && wb_data == e.data
                        && wb_illegal == e.ill)
                else bad_value($sformatf("wb id %0d rd %0d data %h ill %0b, exp %0d %0d %h %0b",
                                         wb_id, wb_rd_addr, wb_data, wb_illegal,
                                         e.id, e.rd, e.data, e.ill));
                busy[wb_id] = 1'b0;
                owed++;
            end
            if (issue_credit) begin
                credits++;  // one issue credit back per result that leaves.
            end
            assert (credits <= INFLIGHT_DEPTH)
            else bad_value("more issue credits returned than were spent");
            give_credit = release_en && owed > 0 && (!random_release || $urandom_range(1) == 1);
            if (give_credit) owed--;
        end
    end

    always @(posedge clk) begin
        #1;
        wb_credit = give_credit;  // one-cycle pulse per returned credit.
    end

    task automatic check_reset_credits();
        repeat (4) begin
            assert (!wb_valid && !issue_credit)
            else bad_value("wb_valid or issue_credit high after reset");
            @(posedge clk);
            #1;
        end
        assert (credits == INFLIGHT_DEPTH) else bad_value("wrong issue credits after reset");
        for (int k = 0; k < INFLIGHT_DEPTH; k++) begin
            issue_one(r_word(7'h00, 3'd0, 5'(k + 1)), 32'(k), 32'h10);
        end
        wait_drain();
    endtask

    task automatic run_reg_ops();
        issue_one(r_word(7'h00, 3'd0, 5'd1), 32'h7fff_ffff, 32'h1);         // add overflow.
        issue_one(r_word(7'h00, 3'd0, 5'd2), 32'hffff_ffff, 32'h1);         // carry out.
        issue_one(r_word(7'h20, 3'd0, 5'd3), 32'h0, 32'h1);
        issue_one(r_word(7'h20, 3'd0, 5'd4), 32'h8000_0000, 32'h1);         // sub overflow.
        issue_one(r_word(7'h00, 3'd2, 5'd5), 32'hffff_ffff, 32'h1);
        issue_one(r_word(7'h00, 3'd2, 5'd6), 32'h1, 32'hffff_ffff);
        issue_one(r_word(7'h00, 3'd2, 5'd7), 32'h8000_0000, 32'h7fff_ffff);
        issue_one(r_word(7'h00, 3'd3, 5'd8), 32'hffff_ffff, 32'h1);
        issue_one(r_word(7'h00, 3'd3, 5'd9), 32'h1, 32'hffff_ffff);
        issue_one(r_word(7'h00, 3'd3, 5'd10), 32'h5, 32'h5);                 // equal.
        issue_one(r_word(7'h00, 3'd4, 5'd11), 32'hf0f0_1234, 32'h0ff0_ffff);
        issue_one(r_word(7'h00, 3'd6, 5'd12), 32'hf0f0_1234, 32'h0ff0_0000);
        issue_one(r_word(7'h00, 3'd7, 5'd13), 32'hf0f0_1234, 32'h0ff0_ff00);
        wait_drain();
    endtask

    task automatic run_imm_shifts();
        logic [4:0] amt [3] = '{5'd0, 5'd1, 5'd31};
        issue_one(i_word(12'hfff, 3'd0, 5'd1), 32'h10, 32'h0);              // addi -1.
        issue_one(i_word(12'h800, 3'd0, 5'd2), 32'h0, 32'h0);               // addi -2048.
        issue_one(i_word(12'hffe, 3'd2, 5'd3), 32'hffff_ffff, 32'h0);
        issue_one(i_word(12'hfff, 3'd3, 5'd4), 32'h7fff_ffff, 32'h0);       // sltiu vs max.
        issue_one(i_word(12'hfff, 3'd4, 5'd5), 32'h1234_5678, 32'h0);       // not.
        issue_one(i_word(12'h8f0, 3'd6, 5'd6), 32'h0000_000f, 32'h0);
        issue_one(i_word(12'h80f, 3'd7, 5'd7), 32'hffff_0ff0, 32'h0);
        foreach (amt[k]) begin
            issue_one(r_word(7'h00, 3'd1, 5'd8), 32'h8000_00f1, {27'h7ff_ffff, amt[k]});
            issue_one(r_word(7'h00, 3'd5, 5'd9), 32'h8000_00f1, {27'h7ff_ffff, amt[k]});
            issue_one(r_word(7'h20, 3'd5, 5'd10), 32'h8000_00f1, {27'h0, amt[k]});
            issue_one(i_word({7'h00, amt[k]}, 3'd1, 5'd11), 32'hc000_1234, 32'h0);
            issue_one(i_word({7'h00, amt[k]}, 3'd5, 5'd12), 32'hc000_1234, 32'h0);
            issue_one(i_word({7'h20, amt[k]}, 3'd5, 5'd13), 32'hc000_1234, 32'h0);
        end
        wait_drain();
    endtask

    task automatic hold_backpressure();
        int n;
        release_en = 1'b0;
        for (int k = 0; k < INFLIGHT_DEPTH; k++) begin
            issue_one(r_word(7'h20, 3'd0, 5'(20 + k)), 32'(100 * k), 32'h7);
        end
        n = 0;
        while (exp_q.size() > INFLIGHT_DEPTH - WB_CREDITS) begin
            @(posedge clk);
            #1;
            n++;
            if (n > 20) timed_out("waiting for the credited writebacks");
        end
        repeat (8) @(posedge clk);
        #1;
        assert (exp_q.size() == INFLIGHT_DEPTH - WB_CREDITS && credits == WB_CREDITS)
        else bad_value("results left without downstream credit");
        release_en = 1'b1;
        wait_drain();
    endtask

    task automatic send_illegal();
        issue_one(r_word(7'h00, 3'd0, 5'd1), 32'h3, 32'h4);
        issue_one({25'h0ab_cdef, 7'b1100011}, 32'hffff_ffff, 32'h1);         // branch opcode.
        issue_one({25'h155_5555, 7'b0000011}, 32'h1, 32'h1);                 // load opcode.
        issue_one(i_word(12'h7ff, 3'd0, 5'd2), 32'h1, 32'h0);
        wait_drain();
    endtask

    task automatic mix_random();
        logic [31:0] instr;
        logic [31:0] a;
        logic [31:0] b;
        logic [2:0]  f3;
        logic [6:0]  f7;
        int          sel;
        random_release = 1'b1;
        pick_random    = 1'b1;
        for (int n = 0; n < n_random; n++) begin
            f3  = 3'($urandom_range(7));
            f7  = ((f3 == 3'd0 || f3 == 3'd5) && $urandom_range(1) == 1) ? 7'h20 : 7'h00;
            sel = $urandom_range(9);
            if (sel < 5) instr = {f7, 10'($urandom), f3, 5'($urandom), op_reg};
            else if (sel < 9 && (f3 == 3'd1 || f3 == 3'd5))
                instr = {f7, 10'($urandom), f3, 5'($urandom), op_imm};
            else if (sel < 9) instr = {17'($urandom), f3, 5'($urandom), op_imm};
            else instr = {25'($urandom), 7'b0100011};                       // store opcode.
            a = ($urandom_range(3) == 0) ? 32'h8000_0000 : $urandom;
            b = ($urandom_range(3) == 0) ? 32'hffff_ffff : $urandom;
            issue_one(instr, a, b);
        end
        random_release = 1'b0;
        pick_random    = 1'b0;
        wait_drain();
    endtask

    initial begin
        repeat (run_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles", run_cycles);
        stop_run();
    end

    initial begin
        void'($urandom(32'hf426));
        rst            = 1'b1;
        issue_valid    = 1'b0;
        issue_id       = '0;
        issue_instr    = '0;
        rs1_data       = '0;
        rs2_data       = '0;
        wb_credit      = 1'b0;
        give_credit    = 1'b0;
        credits        = INFLIGHT_DEPTH;
        owed           = 0;
        release_en     = 1'b1;
        random_release = 1'b0;
        pick_random    = 1'b0;
        foreach (busy[k]) busy[k] = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        check_reset_credits();
        run_reg_ops();
        run_imm_shifts();
        hold_backpressure();
        send_illegal();
        mix_random();
        if (u_alu_exec_top.u_queue.u_chk.violations == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("bound queue assertions failed");
            stop_run();
        end
    end

endmodule

`default_nettype wire

/* alu_exec.f */
rtl/alu_pkg.sv
rtl/alu_decode.sv
rtl/barrel_shifter.sv
rtl/alu_unit.sv
rtl/writeback_queue.sv
rtl/alu_exec_top.sv
sim/alu_exec_chk.sv
sim/alu_exec_tb.sv

/* Bender.yml */
package:
  name: alu_exec

sources:
  - rtl/alu_pkg.sv
  - rtl/alu_decode.sv
  - rtl/barrel_shifter.sv
  - rtl/alu_unit.sv
  - rtl/writeback_queue.sv
  - rtl/alu_exec_top.sv
  - target: test
    files:
      - sim/alu_exec_chk.sv
      - sim/alu_exec_tb.sv
